// File: logic/zbus_pkg.sv
/*
 * Z80 bus widths and address map
 * Region type for decoded Z80 accesses
 */
package zbus_pkg;

	// ############################################################
	// Widths
	// ############################################################

	localparam int ZA_W   = 16;
	localparam int ZD_W   = 8;
	localparam int BANK_W = 9;
	localparam int WIN_W  = 15;

	// ############################################################
	// Address map
	// ############################################################

	typedef enum logic [2:0]
	{
		REG_RAM,
		REG_SOUND,
		REG_BANK,
		REG_WINDOW,
		REG_NONE
	} zregion_e;

	// Local RAM starts at 0x0000
	localparam logic [ZA_W-1:0] RAM_END   = 16'h3FFF;
	localparam logic [ZA_W-1:0] SOUND_END = 16'h5FFF;
	localparam logic [ZA_W-1:0] BANK_BASE = 16'h6000;
	localparam logic [ZA_W-1:0] BANK_END  = 16'h60FF;

	// Window runs to the top of the Z80 space
	localparam logic [ZA_W-1:0] WIN_BASE  = 16'h8000;

	// Value returned by reads that do not reach the 68000 bus
	localparam logic [ZD_W-1:0] OPEN_BUS  = 8'hFF;

endpackage

// File: logic/mbus_pkg.sv
/*
 * 68000 bus widths and Z80 control register map
 * Opcode type for the control port
 */
package mbus_pkg;

	// ############################################################
	// Widths
	// ############################################################

	localparam int MA_W = 24;
	localparam int MD_W = 16;

	// ############################################################
	// Z80 control registers
	// ############################################################

	localparam logic [MA_W-1:0] BUSREQ_ADDR = 24'hA11100;
	localparam logic [MA_W-1:0] ZRESET_ADDR = 24'hA11200;

	// Both registers live on the upper data byte
	localparam int CTRL_BIT = 8;

	typedef enum logic
	{
		OP_READ,
		OP_WRITE
	} ctrl_op_e;

endpackage

// File: logic/z80_addr_decode.sv
/*
 * First pipeline stage
 * Accepts Z80 accesses and tags them with their address region
 */
`timescale 1ns/1ns
module z80_addr_decode
	(
	input  logic                       MCLK,
	input  logic                       reset_i,
	input  logic                       z_req_i,
	input  logic [zbus_pkg::ZA_W-1:0]  z_addr_i,
	input  logic                       z_we_i,
	input  logic [zbus_pkg::ZD_W-1:0]  z_wdata_i,
	input  logic                       z80_busreq_i,
	input  logic                       z80_reset_i,
	input  logic                       dec_ack_i,
	output logic                       z_ack_o,
	output logic                       dec_req_o,
	output zbus_pkg::zregion_e         dec_region_o,
	output logic [zbus_pkg::ZA_W-1:0]  dec_addr_o,
	output logic                       dec_we_o,
	output logic [zbus_pkg::ZD_W-1:0]  dec_wdata_o
	);

	import zbus_pkg::*;

	typedef enum logic [1:0] {IDLE, HOLD, RELEASE} state_e;

	state_e state;
	logic   accept;

	function automatic zregion_e classify(input logic [ZA_W-1:0] addr);
		zregion_e region;
		if (addr <= RAM_END)
			region = REG_RAM;
		else if (addr <= SOUND_END)
			region = REG_SOUND;
		else if (addr >= BANK_BASE && addr <= BANK_END)
			region = REG_BANK;
		else if (addr >= WIN_BASE)
			region = REG_WINDOW;
		else
			region = REG_NONE;
		return region;
	endfunction

	// Z80 is frozen while the 68000 holds its bus or its reset
	assign accept = (state == IDLE) && z_req_i && !z_ack_o
		&& !z80_busreq_i && !z80_reset_i;

	always_ff @(posedge MCLK)
	begin
		if (reset_i)
		begin
			state     <= IDLE;
			z_ack_o   <= 1'b0;
			dec_req_o <= 1'b0;
		end
		else
		begin
			if (accept)
				z_ack_o <= 1'b1;
			else if (z_ack_o && !z_req_i)
				z_ack_o <= 1'b0;

			case (state)
				IDLE:
				begin
					if (accept)
					begin
						dec_req_o <= 1'b1;
						state     <= HOLD;
					end
				end
				HOLD:
				begin
					if (dec_ack_i)
					begin
						dec_req_o <= 1'b0;
						state     <= RELEASE;
					end
				end
				default:
				begin
					// Stage is empty once the bank stage lets go of ack
					if (!dec_ack_i)
						state <= IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge MCLK)
	begin
		if (accept)
		begin
			dec_region_o <= classify(z_addr_i);
			dec_addr_o   <= z_addr_i;
			dec_we_o     <= z_we_i;
			dec_wdata_o  <= z_wdata_i;
		end
	end

endmodule

// File: logic/z80_bank_window.sv
/*
 * Second pipeline stage
 * Bank register and 68000 address forming for the Z80 window
 */
`timescale 1ns/1ns
module z80_bank_window
	(
	input  logic                       MCLK,
	input  logic                       reset_i,
	input  logic                       dec_req_i,
	input  zbus_pkg::zregion_e         dec_region_i,
	input  logic [zbus_pkg::ZA_W-1:0]  dec_addr_i,
	input  logic                       dec_we_i,
	input  logic [zbus_pkg::ZD_W-1:0]  dec_wdata_i,
	input  logic                       win_ack_i,
	output logic                       dec_ack_o,
	output logic                       win_req_o,
	output zbus_pkg::zregion_e         win_region_o,
	output logic [mbus_pkg::MA_W-1:0]  win_maddr_o,
	output logic                       win_we_o,
	output logic [zbus_pkg::ZD_W-1:0]  win_wdata_o
	);

	import zbus_pkg::*;

	logic [BANK_W-1:0] bank_q;
	logic              accept;
	logic              bank_wr;

	// Downstream handshake must be fully closed before taking the next item
	assign accept  = dec_req_i && !dec_ack_o && !win_req_o && !win_ack_i;
	assign bank_wr = accept && dec_we_i && (dec_region_i == REG_BANK);

	always_ff @(posedge MCLK)
	begin
		if (reset_i)
		begin
			dec_ack_o <= 1'b0;
			win_req_o <= 1'b0;
		end
		else
		begin
			if (accept)
				dec_ack_o <= 1'b1;
			else if (dec_ack_o && !dec_req_i)
				dec_ack_o <= 1'b0;

			if (accept)
				win_req_o <= 1'b1;
			else if (win_req_o && win_ack_i)
				win_req_o <= 1'b0;
		end
	end

	// ############################################################
	// Bank register
	// ############################################################

	// Serial load, one data bit per write, entering at the top
	always_ff @(posedge MCLK)
	begin
		if (reset_i)
			bank_q <= '0;
		else if (bank_wr)
			bank_q <= {dec_wdata_i[0], bank_q[BANK_W-1:1]};
	end

	// ############################################################
	// Outgoing access
	// ############################################################

	always_ff @(posedge MCLK)
	begin
		if (accept)
		begin
			win_region_o <= dec_region_i;
			win_maddr_o  <= {bank_q, dec_addr_i[WIN_W-1:0]};
			win_we_o     <= dec_we_i;
			win_wdata_o  <= dec_wdata_i;
		end
	end

endmodule

// File: logic/main_bus_bridge.sv
/*
 * Third pipeline stage
 * Runs 68000 bus cycles for window accesses and issues completions
 */
`timescale 1ns/1ns
module main_bus_bridge
	(
	input  logic                       MCLK,
	input  logic                       reset_i,
	input  logic                       win_req_i,
	input  zbus_pkg::zregion_e         win_region_i,
	input  logic [mbus_pkg::MA_W-1:0]  win_maddr_i,
	input  logic                       win_we_i,
	input  logic [zbus_pkg::ZD_W-1:0]  win_wdata_i,
	input  logic                       mb_ack_i,
	input  logic [zbus_pkg::ZD_W-1:0]  mb_rdata_i,
	input  logic                       cpl_ack_i,
	output logic                       win_ack_o,
	output logic                       mb_req_o,
	output logic [mbus_pkg::MA_W-1:0]  mb_addr_o,
	output logic                       mb_we_o,
	output logic [zbus_pkg::ZD_W-1:0]  mb_wdata_o,
	output logic                       cpl_req_o,
	output zbus_pkg::zregion_e         cpl_region_o,
	output logic [zbus_pkg::ZD_W-1:0]  cpl_rdata_o
	);

	import zbus_pkg::*;
	import mbus_pkg::*;

	typedef enum logic [2:0] {IDLE, BUS_REQ, BUS_REL, CPL, CPL_REL} state_e;

	state_e            state;
	logic              accept;
	zregion_e          region_q;
	logic [MA_W-1:0]   maddr_q;
	logic              we_q;
	logic [ZD_W-1:0]   wdata_q;

	assign accept = (state == IDLE) && win_req_i && !win_ack_o;

	always_ff @(posedge MCLK)
	begin
		if (reset_i)
		begin
			state     <= IDLE;
			win_ack_o <= 1'b0;
			mb_req_o  <= 1'b0;
			cpl_req_o <= 1'b0;
		end
		else
		begin
			if (accept)
				win_ack_o <= 1'b1;
			else if (win_ack_o && !win_req_i)
				win_ack_o <= 1'b0;

			case (state)
				IDLE:
				begin
					if (accept)
					begin
						// Only the window goes out on the 68000 bus
						if (win_region_i == REG_WINDOW)
						begin
							mb_req_o <= 1'b1;
							state    <= BUS_REQ;
						end
						else
						begin
							cpl_req_o <= 1'b1;
							state     <= CPL;
						end
					end
				end
				BUS_REQ:
				begin
					if (mb_ack_i)
					begin
						mb_req_o <= 1'b0;
						state    <= BUS_REL;
					end
				end
				BUS_REL:
				begin
					if (!mb_ack_i)
					begin
						cpl_req_o <= 1'b1;
						state     <= CPL;
					end
				end
				CPL:
				begin
					if (cpl_ack_i)
					begin
						cpl_req_o <= 1'b0;
						state     <= CPL_REL;
					end
				end
				default:
				begin
					if (!cpl_ack_i)
						state <= IDLE;
				end
			endcase
		end
	end

	// ############################################################
	// Access payload and read data
	// ############################################################

	always_ff @(posedge MCLK)
	begin
		if (accept)
		begin
			region_q    <= win_region_i;
			maddr_q     <= win_maddr_i;
			we_q        <= win_we_i;
			wdata_q     <= win_wdata_i;
			cpl_rdata_o <= OPEN_BUS;
		end
		else if (state == BUS_REQ && mb_ack_i && !we_q)
			cpl_rdata_o <= mb_rdata_i;
	end

	assign mb_addr_o    = maddr_q;
	assign mb_we_o      = we_q;
	assign mb_wdata_o   = wdata_q;
	assign cpl_region_o = region_q;

endmodule

// File: logic/z80_ctrl_regs.sv
/*
 * Z80 bus-request and reset registers on the 68000 side
 */
`timescale 1ns/1ns
module z80_ctrl_regs
	(
	input  logic                       MCLK,
	input  logic                       reset_i,
	input  logic                       m_req_i,
	input  mbus_pkg::ctrl_op_e         m_op_i,
	input  logic [mbus_pkg::MA_W-1:0]  m_addr_i,
	input  logic [mbus_pkg::MD_W-1:0]  m_wdata_i,
	output logic                       m_ack_o,
	output logic [mbus_pkg::MD_W-1:0]  m_rdata_o,
	output logic                       z80_busreq_o,
	output logic                       z80_reset_o
	);

	import mbus_pkg::*;

	logic accept;

	assign accept = m_req_i && !m_ack_o;

	always_ff @(posedge MCLK)
	begin
		if (reset_i)
		begin
			m_ack_o      <= 1'b0;
			z80_busreq_o <= 1'b0;
			// Z80 comes out of system reset held in reset
			z80_reset_o  <= 1'b1;
		end
		else if (accept)
		begin
			m_ack_o <= 1'b1;
			if (m_op_i == OP_WRITE)
			begin
				if (m_addr_i == BUSREQ_ADDR)
					z80_busreq_o <= m_wdata_i[CTRL_BIT];
				else if (m_addr_i == ZRESET_ADDR)
					z80_reset_o <= !m_wdata_i[CTRL_BIT];
			end
		end
		else if (m_ack_o && !m_req_i)
			m_ack_o <= 1'b0;
	end

	// Only the bus-request bit reads back
	always_ff @(posedge MCLK)
	begin
		if (accept)
		begin
			m_rdata_o <= '0;
			if (m_op_i == OP_READ && m_addr_i == BUSREQ_ADDR)
				m_rdata_o[CTRL_BIT] <= z80_busreq_o;
		end
	end

endmodule

// File: logic/bus_ctrl_top.sv
/*
 * Z80 bus control top level
 * Decode, bank window and bridge stages plus the control registers
 */
`timescale 1ns/1ns
module bus_ctrl_top
	(
	input  logic                       MCLK,
	input  logic                       reset_i,
	input  logic                       z_req_i,
	input  logic [zbus_pkg::ZA_W-1:0]  z_addr_i,
	input  logic                       z_we_i,
	input  logic [zbus_pkg::ZD_W-1:0]  z_wdata_i,
	output logic                       z_ack_o,
	output logic                       mb_req_o,
	output logic [mbus_pkg::MA_W-1:0]  mb_addr_o,
	output logic                       mb_we_o,
	output logic [zbus_pkg::ZD_W-1:0]  mb_wdata_o,
	input  logic                       mb_ack_i,
	input  logic [zbus_pkg::ZD_W-1:0]  mb_rdata_i,
	output logic                       cpl_req_o,
	output zbus_pkg::zregion_e         cpl_region_o,
	output logic [zbus_pkg::ZD_W-1:0]  cpl_rdata_o,
	input  logic                       cpl_ack_i,
	input  logic                       m_req_i,
	input  mbus_pkg::ctrl_op_e         m_op_i,
	input  logic [mbus_pkg::MA_W-1:0]  m_addr_i,
	input  logic [mbus_pkg::MD_W-1:0]  m_wdata_i,
	output logic                       m_ack_o,
	output logic [mbus_pkg::MD_W-1:0]  m_rdata_o,
	output logic                       z80_busreq_o,
	output logic                       z80_reset_o
	);

	import zbus_pkg::*;
	import mbus_pkg::*;

	// Decode to bank link
	logic            dec_req;
	logic            dec_ack;
	zregion_e        dec_region;
	logic [ZA_W-1:0] dec_addr;
	logic            dec_we;
	logic [ZD_W-1:0] dec_wdata;

	// Bank to bridge link
	logic            win_req;
	logic            win_ack;
	zregion_e        win_region;
	logic [MA_W-1:0] win_maddr;
	logic            win_we;
	logic [ZD_W-1:0] win_wdata;

	z80_addr_decode u_decode
		(
		.MCLK(MCLK), .reset_i(reset_i),
		.z_req_i(z_req_i), .z_addr_i(z_addr_i), .z_we_i(z_we_i), .z_wdata_i(z_wdata_i),
		.z80_busreq_i(z80_busreq_o), .z80_reset_i(z80_reset_o),
		.dec_ack_i(dec_ack), .z_ack_o(z_ack_o), .dec_req_o(dec_req),
		.dec_region_o(dec_region), .dec_addr_o(dec_addr), .dec_we_o(dec_we),
		.dec_wdata_o(dec_wdata)
		);

	z80_bank_window u_bank
		(
		.MCLK(MCLK), .reset_i(reset_i),
		.dec_req_i(dec_req), .dec_region_i(dec_region), .dec_addr_i(dec_addr),
		.dec_we_i(dec_we), .dec_wdata_i(dec_wdata), .win_ack_i(win_ack),
		.dec_ack_o(dec_ack), .win_req_o(win_req), .win_region_o(win_region),
		.win_maddr_o(win_maddr), .win_we_o(win_we), .win_wdata_o(win_wdata)
		);

	main_bus_bridge u_bridge
		(
		.MCLK(MCLK), .reset_i(reset_i),
		.win_req_i(win_req), .win_region_i(win_region), .win_maddr_i(win_maddr),
		.win_we_i(win_we), .win_wdata_i(win_wdata),
		.mb_ack_i(mb_ack_i), .mb_rdata_i(mb_rdata_i), .cpl_ack_i(cpl_ack_i),
		.win_ack_o(win_ack), .mb_req_o(mb_req_o), .mb_addr_o(mb_addr_o),
		.mb_we_o(mb_we_o), .mb_wdata_o(mb_wdata_o), .cpl_req_o(cpl_req_o),
		.cpl_region_o(cpl_region_o), .cpl_rdata_o(cpl_rdata_o)
		);

	z80_ctrl_regs u_ctrl
		(
		.MCLK(MCLK), .reset_i(reset_i),
		.m_req_i(m_req_i), .m_op_i(m_op_i), .m_addr_i(m_addr_i), .m_wdata_i(m_wdata_i),
		.m_ack_o(m_ack_o), .m_rdata_o(m_rdata_o),
		.z80_busreq_o(z80_busreq_o), .z80_reset_o(z80_reset_o)
		);

endmodule

// File: dv/bus_ctrl_tb_util.svh
/*
 * Reference model for a Z80 access, LFSR step and value check
 */
`ifndef BUS_CTRL_TB_UTIL_SVH
`define BUS_CTRL_TB_UTIL_SVH

// Expected region, 68000 address, read data and next bank value
function automatic void expected_access(
	input  logic [ZA_W-1:0]   addr,
	input  logic              we,
	input  logic [ZD_W-1:0]   wdata,
	input  logic [BANK_W-1:0] bank,
	output zregion_e          region,
	output logic [MA_W-1:0]   maddr,
	output logic [ZD_W-1:0]   rdata,
	output logic [BANK_W-1:0] bank_next);
	if (addr[15])
		region = REG_WINDOW;
	else if (addr[15:14] == 2'b00)
		region = REG_RAM;
	else if (addr[15:13] == 3'b010)
		region = REG_SOUND;
	else if (addr[15:8] == 8'h60)
		region = REG_BANK;
	else
		region = REG_NONE;

	maddr = {bank, addr[14:0]};

	// Responder returns low address byte XOR high address byte
	rdata = OPEN_BUS;
	if (region == REG_WINDOW && !we)
		rdata = maddr[7:0] ^ maddr[23:16];

	bank_next = bank;
	if (region == REG_BANK && we)
		bank_next = {wdata[0], bank[BANK_W-1:1]};
endfunction

// Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
	logic feedback;
	feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
	return {state[14:0], feedback};
endfunction

task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
	input string what);
	if (actual !== expected)
		abort_run($sformatf("Error at %0t ns: %s is 0x%0h, expected 0x%0h",
			$time, what, actual, expected));
endtask

`endif

// File: dv/bus_ctrl_tb.sv
/*
 * Testbench for the Z80 bus control top level
 * Stimulus, 68000 bus responder and completion checker
 */
`timescale 1ns/1ns
module bus_ctrl_tb;

	import zbus_pkg::*;
	import mbus_pkg::*;

	localparam int HALF_PERIOD   = 20;
	localparam int RESET_CYCLES  = 3;
	localparam int ACK_TIMEOUT   = 200;
	localparam int DRAIN_TIMEOUT = 2000;
	localparam int HOLD_CYCLES   = 20;
	localparam int DEPTH         = 64;
	localparam logic [15:0] SEED = 16'd50;
	localparam logic [MD_W-1:0] CTRL_SET = 16'h0100;

	logic            MCLK = 1'b0;
	logic            reset_i;
	logic            z_req_i;
	logic [ZA_W-1:0] z_addr_i;
	logic            z_we_i;
	logic [ZD_W-1:0] z_wdata_i;
	logic            z_ack_o;
	logic            mb_req_o;
	logic [MA_W-1:0] mb_addr_o;
	logic            mb_we_o;
	logic [ZD_W-1:0] mb_wdata_o;
	logic            mb_ack_i = 1'b0;
	logic [ZD_W-1:0] mb_rdata_i = '0;
	logic            cpl_req_o;
	zregion_e        cpl_region_o;
	logic [ZD_W-1:0] cpl_rdata_o;
	logic            cpl_ack_i = 1'b0;
	logic            m_req_i;
	ctrl_op_e        m_op_i;
	logic [MA_W-1:0] m_addr_i;
	logic [MD_W-1:0] m_wdata_i;
	logic            m_ack_o;
	logic [MD_W-1:0] m_rdata_o;
	logic            z80_busreq_o;
	logic            z80_reset_o;

	// Expected completions and 68000 cycles, in issue order
	zregion_e          exp_region [DEPTH];
	logic [ZD_W-1:0]   exp_rdata  [DEPTH];
	logic [MA_W-1:0]   exp_maddr  [DEPTH];
	logic              exp_mwe    [DEPTH];
	logic [ZD_W-1:0]   exp_mwdata [DEPTH];
	int                issue_count = 0;
	int                cpl_count   = 0;
	int                mb_count    = 0;
	int                mb_seen     = 0;
	logic [BANK_W-1:0] bank_model  = '0;
	logic [15:0]       stim_lfsr   = SEED;
	logic [15:0]       resp_lfsr   = SEED;
	logic              cpl_stall   = 1'b0;
	logic              mb_busy     = 1'b0;
	int                mb_wait     = 0;
	logic [31:0]       resp_bits;

	always #HALF_PERIOD MCLK = ~MCLK;

	bus_ctrl_top u_bus_ctrl_top
		(
		.MCLK(MCLK), .reset_i(reset_i),
		.z_req_i(z_req_i), .z_addr_i(z_addr_i), .z_we_i(z_we_i), .z_wdata_i(z_wdata_i),
		.z_ack_o(z_ack_o),
		.mb_req_o(mb_req_o), .mb_addr_o(mb_addr_o), .mb_we_o(mb_we_o),
		.mb_wdata_o(mb_wdata_o), .mb_ack_i(mb_ack_i), .mb_rdata_i(mb_rdata_i),
		.cpl_req_o(cpl_req_o), .cpl_region_o(cpl_region_o), .cpl_rdata_o(cpl_rdata_o),
		.cpl_ack_i(cpl_ack_i),
		.m_req_i(m_req_i), .m_op_i(m_op_i), .m_addr_i(m_addr_i), .m_wdata_i(m_wdata_i),
		.m_ack_o(m_ack_o), .m_rdata_o(m_rdata_o),
		.z80_busreq_o(z80_busreq_o), .z80_reset_o(z80_reset_o)
		);

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Verification failed");
		$fatal(1);
	endtask

	`include "bus_ctrl_tb_util.svh"

	task automatic take_bits(inout logic [15:0] state, input int n, output logic [31:0] bits);
		int i;
		bits = '0;
		for (i = 0; i < n; i++)
		begin
			state = lfsr_next(state);
			bits  = {bits[30:0], state[0]};
		end
	endtask

	// ############################################################
	// Z80 and control port drivers
	// ############################################################

	task automatic z80_issue(input logic [ZA_W-1:0] addr, input logic we,
		input logic [ZD_W-1:0] wdata);
		zregion_e          region;
		logic [MA_W-1:0]   maddr;
		logic [ZD_W-1:0]   rdata;
		logic [BANK_W-1:0] bank_next;
		expected_access(addr, we, wdata, bank_model, region, maddr, rdata, bank_next);
		bank_model = bank_next;
		@(posedge MCLK);
		exp_region[issue_count % DEPTH] <= region;
		exp_rdata[issue_count % DEPTH]  <= rdata;
		issue_count <= issue_count + 1;
		if (region == REG_WINDOW)
		begin
			exp_maddr[mb_count % DEPTH]  <= maddr;
			exp_mwe[mb_count % DEPTH]    <= we;
			exp_mwdata[mb_count % DEPTH] <= wdata;
			mb_count <= mb_count + 1;
		end
		z_req_i   <= 1'b1;
		z_addr_i  <= addr;
		z_we_i    <= we;
		z_wdata_i <= wdata;
	endtask

	task automatic z80_finish();
		int cycles;
		cycles = 0;
		while (!z_ack_o)
		begin
			@(posedge MCLK);
			cycles++;
			if (cycles > ACK_TIMEOUT)
				abort_run("Timed out waiting for the Z80 ack to rise");
		end
		z_req_i <= 1'b0;
		cycles = 0;
		while (z_ack_o)
		begin
			@(posedge MCLK);
			cycles++;
			if (cycles > ACK_TIMEOUT)
				abort_run("Timed out waiting for the Z80 ack to fall");
		end
	endtask

	task automatic z80_access(input logic [ZA_W-1:0] addr, input logic we,
		input logic [ZD_W-1:0] wdata);
		z80_issue(addr, we, wdata);
		z80_finish();
	endtask

	task automatic ctrl_access(input ctrl_op_e op, input logic [MA_W-1:0] addr,
		input logic [MD_W-1:0] wdata, output logic [MD_W-1:0] rdata);
		int cycles;
		@(posedge MCLK);
		m_req_i   <= 1'b1;
		m_op_i    <= op;
		m_addr_i  <= addr;
		m_wdata_i <= wdata;
		cycles = 0;
		while (!m_ack_o)
		begin
			@(posedge MCLK);
			cycles++;
			if (cycles > ACK_TIMEOUT)
				abort_run("Timed out waiting for the control port ack to rise");
		end
		rdata = m_rdata_o;
		m_req_i <= 1'b0;
		cycles = 0;
		while (m_ack_o)
		begin
			@(posedge MCLK);
			cycles++;
			if (cycles > ACK_TIMEOUT)
				abort_run("Timed out waiting for the control port ack to fall");
		end
	endtask

	task automatic expect_no_ack();
		int i;
		for (i = 0; i < HOLD_CYCLES; i++)
		begin
			@(posedge MCLK);
			check_value(32'(z_ack_o), 32'd0, "z_ack_o while the Z80 is held off");
		end
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (cpl_count != issue_count || mb_seen != mb_count)
		begin
			@(posedge MCLK);
			cycles++;
			if (cycles > DRAIN_TIMEOUT)
				abort_run("Timed out waiting for outstanding accesses to complete");
		end
	endtask

	// ############################################################
	// 68000 bus responder and completion checker
	// ############################################################

	always @(posedge MCLK)
	begin
		if (reset_i)
		begin
			mb_ack_i <= 1'b0;
			mb_busy = 1'b0;
		end
		else if (mb_req_o && !mb_ack_i)
		begin
			if (!mb_busy)
			begin
				if (mb_seen == mb_count)
					abort_run("The 68000 bus was requested with no window access outstanding");
				check_value(32'(mb_addr_o), 32'(exp_maddr[mb_seen % DEPTH]), "mb_addr_o");
				check_value(32'(mb_we_o), 32'(exp_mwe[mb_seen % DEPTH]), "mb_we_o");
				if (exp_mwe[mb_seen % DEPTH])
					check_value(32'(mb_wdata_o), 32'(exp_mwdata[mb_seen % DEPTH]),
						"mb_wdata_o");
				mb_seen <= mb_seen + 1;
				take_bits(resp_lfsr, 3, resp_bits);
				mb_wait = int'(resp_bits[2:0]);
				mb_busy = 1'b1;
			end
			if (mb_wait == 0)
			begin
				mb_ack_i   <= 1'b1;
				mb_rdata_i <= mb_addr_o[7:0] ^ mb_addr_o[23:16];
				mb_busy = 1'b0;
			end
			else
				mb_wait--;
		end
		else if (mb_ack_i && !mb_req_o)
			mb_ack_i <= 1'b0;
	end

	always @(posedge MCLK)
	begin
		if (reset_i)
			cpl_ack_i <= 1'b0;
		else if (cpl_req_o && !cpl_ack_i && !cpl_stall)
		begin
			if (cpl_count == issue_count)
				abort_run("A completion arrived with no Z80 access outstanding");
			check_value(32'(cpl_region_o), 32'(exp_region[cpl_count % DEPTH]),
				"cpl_region_o");
			check_value(32'(cpl_rdata_o), 32'(exp_rdata[cpl_count % DEPTH]), "cpl_rdata_o");
			cpl_count <= cpl_count + 1;
			cpl_ack_i <= 1'b1;
		end
		else if (cpl_ack_i && !cpl_req_o)
			cpl_ack_i <= 1'b0;
	end

	// ############################################################
	// Stimulus
	// ############################################################

	initial
	begin
		logic [31:0]     bits;
		logic [MD_W-1:0] rd;
		logic [ZA_W-1:0] addr;
		int              i;
		reset_i   = 1'b1;
		z_req_i   = 1'b0;
		z_addr_i  = '0;
		z_we_i    = 1'b0;
		z_wdata_i = '0;
		m_req_i   = 1'b0;
		m_op_i    = OP_READ;
		m_addr_i  = '0;
		m_wdata_i = '0;
		repeat (RESET_CYCLES) @(posedge MCLK);
		reset_i <= 1'b0;
		@(posedge MCLK);

		// Z80 held in reset until the 68000 releases it
		check_value(32'(z80_reset_o), 32'd1, "z80_reset_o after reset");
		check_value(32'(z80_busreq_o), 32'd0, "z80_busreq_o after reset");
		take_bits(stim_lfsr, 14, bits);
		z80_issue({2'b00, bits[13:0]}, 1'b0, 8'h00);
		expect_no_ack();
		ctrl_access(OP_WRITE, ZRESET_ADDR, CTRL_SET, rd);
		check_value(32'(z80_reset_o), 32'd0, "z80_reset_o after release");
		z80_finish();
		wait_drain();

		// Local regions only, no 68000 cycles
		for (i = 0; i < 16; i++)
		begin
			take_bits(stim_lfsr, 25, bits);
			case (bits[1:0])
				2'd0: addr = {2'b00, bits[15:2]};
				2'd1: addr = {3'b010, bits[14:2]};
				2'd2: addr = {4'b0111, bits[13:2]};
				default: addr = {7'b0110001, bits[10:2]};
			endcase
			z80_access(addr, bits[16], bits[24:17]);
		end
		wait_drain();

		// Load the bank register, then use the window
		for (i = 0; i < 9; i++)
		begin
			take_bits(stim_lfsr, 9, bits);
			z80_access({8'h60, bits[7:0]}, 1'b1, {7'b0, bits[8]});
		end
		for (i = 0; i < 16; i++)
		begin
			take_bits(stim_lfsr, 24, bits);
			z80_access({1'b1, bits[14:0]}, bits[15], bits[23:16]);
		end
		wait_drain();

		// Bus request holds off new accesses
		ctrl_access(OP_WRITE, BUSREQ_ADDR, CTRL_SET, rd);
		check_value(32'(z80_busreq_o), 32'd1, "z80_busreq_o after set");
		ctrl_access(OP_READ, BUSREQ_ADDR, '0, rd);
		check_value(32'(rd), 32'(CTRL_SET), "busreq read-back while set");
		take_bits(stim_lfsr, 15, bits);
		z80_issue({1'b1, bits[14:0]}, 1'b0, 8'h00);
		expect_no_ack();
		ctrl_access(OP_WRITE, BUSREQ_ADDR, '0, rd);
		ctrl_access(OP_READ, BUSREQ_ADDR, '0, rd);
		check_value(32'(rd), 32'd0, "busreq read-back while clear");
		z80_finish();
		wait_drain();

		// Stalled completions fill all three stages
		cpl_stall <= 1'b1;
		for (i = 0; i < 3; i++)
		begin
			take_bits(stim_lfsr, 25, bits);
			z80_access(bits[15:0], bits[16], bits[24:17]);
		end
		take_bits(stim_lfsr, 25, bits);
		z80_issue(bits[15:0], bits[16], bits[24:17]);
		expect_no_ack();
		check_value(32'(cpl_req_o), 32'd1, "cpl_req_o while completions are stalled");
		cpl_stall <= 1'b0;
		z80_finish();
		wait_drain();

		$display("Verification passed");
		$finish;
	end

endmodule

// File: src.f
+incdir+dv
logic/zbus_pkg.sv
logic/mbus_pkg.sv
logic/z80_addr_decode.sv
logic/z80_bank_window.sv
logic/main_bus_bridge.sv
logic/z80_ctrl_regs.sv
logic/bus_ctrl_top.sv
dv/bus_ctrl_tb.sv

// File: Makefile
VERILATOR  ?= verilator
FLAGS      := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing
TOP        := bus_ctrl_tb
FILELIST   := src.f
BUILD_DIR  := obj_dir
PASS_TEXT  := Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
